// ==== arith_unit.f ====
+incdir+include
hw/arith_pkg.sv
hw/digit_timing.sv
hw/distributor.sv
hw/biq_adder.sv
hw/accumulator.sv
hw/arith_ctl.sv
hw/arith_unit.sv
bench/arith_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module arith_tb \
   -f arith_unit.f \
   -Mdir obj_dir \
   -o arith_tb_sim

# a $fatal anywhere in the run gives a nonzero status here
./obj_dir/arith_tb_sim

// ==== bench/arith_tb.sv ====
`timescale 1ns/1ps
`include "arith_params.svh"

module arith_tb;
   import arith_pkg::*;

   localparam int n_fixed = 12;
   localparam int n_random = 24;
   localparam int n_rows = n_fixed + n_random;
   localparam longint unsigned word_mod = 64'd10000000000;

   // one line of stimulus with the result the decimal model predicts for it
   typedef struct packed {
      arith_op_e op;
      dec_word_t operand;
      dec_word_t exp_word;
      logic      exp_ovf;
   } row_t;

   logic       ap = 1'b0;
   logic       cp;
   arith_req_t req;
   logic       busy;
   logic       arith_restart;
   logic       end_of_operation;
   dec_word_t  acc_word;
   logic       overflow;
   logic       biq_error;

   row_t            stim_rows [n_rows];
   int              row_count;
   longint unsigned model_acc;
   int              restart_seen;
   int              eop_count = 0;

   arith_unit arith_unit_inst (
      .ap               (ap),
      .cp               (cp),
      .req              (req),
      .busy             (busy),
      .arith_restart    (arith_restart),
      .end_of_operation (end_of_operation),
      .acc_word         (acc_word),
      .overflow         (overflow),
      .biq_error        (biq_error)
   );

   always #2 ap = ~ap;

   // every completed operation is counted, stray pulses included
   always @(negedge ap) begin
      if (!cp && end_of_operation) begin
         eop_count <= eop_count + 1;
      end
   end

   // -------------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------------

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   // one falling edge, noting any restart pulse seen on the way
   task automatic next_cycle();
      @(negedge ap);
      if (arith_restart) begin
         restart_seen++;
      end
   endtask

   function automatic longint unsigned word_value(input dec_word_t w);
      longint unsigned v;
      v = 0;
      for (int i = `ARITH_DIGITS - 1; i >= 0; i--) begin
         v = v * 10 + 64'(w[i]);
      end
      return v;
   endfunction

   function automatic dec_word_t value_word(input longint unsigned v);
      dec_word_t       w;
      longint unsigned r;
      r = v;
      for (int i = 0; i < `ARITH_DIGITS; i++) begin
         w[i] = 4'(r % 10);
         r = r / 10;
      end
      return w;
   endfunction

   function automatic dec_word_t random_word();
      dec_word_t w;
      for (int i = 0; i < `ARITH_DIGITS; i++) begin
         w[i] = 4'($urandom % 10);
      end
      return w;
   endfunction

   // -------------------------------------------------------------------------
   // decimal reference model and stimulus table
   // -------------------------------------------------------------------------

   // subtract is complement addition, so it wraps modulo the word size
   task automatic add_row(input arith_op_e op, input dec_word_t operand);
      longint unsigned opv;
      longint unsigned sum;
      logic            ovf;
      opv = word_value(operand);
      ovf = 1'b0;
      case (op)
         op_reset_add: model_acc = opv;
         op_add: begin
            sum = model_acc + opv;
            ovf = (sum >= word_mod);
            model_acc = sum % word_mod;
         end
         op_subt: model_acc = (model_acc + word_mod - opv) % word_mod;
         op_shift_right: model_acc = model_acc / 10;
         op_shift_left: model_acc = (model_acc * 10) % word_mod;
         default: model_acc = model_acc;
      endcase
      stim_rows[row_count].op = op;
      stim_rows[row_count].operand = operand;
      stim_rows[row_count].exp_word = value_word(model_acc);
      stim_rows[row_count].exp_ovf = ovf;
      row_count++;
   endtask

   task automatic build_table();
      model_acc = 0;
      row_count = 0;
      add_row(op_reset_add, value_word(64'd1234567890));
      add_row(op_add, value_word(64'd8765432109));
      // all nines plus one runs out of the top digit
      add_row(op_add, value_word(64'd1));
      add_row(op_reset_add, value_word(64'd9999999999));
      add_row(op_shift_right, value_word(64'd5555555555));
      add_row(op_shift_left, value_word(64'd7777777777));
      add_row(op_subt, value_word(64'd9999999991));
      add_row(op_add, value_word(64'd2));
      add_row(op_reset_add, value_word(64'd5000000000));
      add_row(op_add, value_word(64'd5000000000));
      add_row(op_subt, value_word(64'd1));
      add_row(op_shift_left, value_word(64'd0));
      for (int i = 0; i < n_random; i++) begin
         add_row(arith_op_e'(3'($urandom % 5)), random_word());
      end
   endtask

   // -------------------------------------------------------------------------
   // applying one row
   // -------------------------------------------------------------------------
   task automatic run_row(input int idx);
      row_t row;
      row = stim_rows[idx];
      while (busy) begin
         next_cycle();
      end
      req.op = row.op;
      req.operand = row.operand;
      req.start = 1'b1;
      restart_seen = 0;
      next_cycle();
      req.start = 1'b0;
      // some rows get a second strobe with junk while the first one runs
      if (idx % 3 == 1) begin
         assert (busy)
            else stop_with_error("the DUT was not busy one cycle after a start strobe");
         req.op = arith_op_e'(3'($urandom % 5));
         req.operand = random_word();
         req.start = 1'b1;
         next_cycle();
         req.start = 1'b0;
      end
      while (!end_of_operation) begin
         next_cycle();
      end
      assert (acc_word == row.exp_word)
         else stop_with_error($sformatf("Mismatch acc_word row %0d: got %h expected %h",
                                        idx, acc_word, row.exp_word));
      assert (overflow == row.exp_ovf)
         else stop_with_error($sformatf("Mismatch overflow row %0d: got %h expected %h",
                                        idx, overflow, row.exp_ovf));
      assert (restart_seen == 1 && !arith_restart)
         else stop_with_error($sformatf(
            "row %0d saw %0d restart pulses ahead of end of operation, not one",
            idx, restart_seen));
      assert (!biq_error)
         else stop_with_error($sformatf("Mismatch biq_error row %0d: got %h expected 0",
                                        idx, biq_error));
   endtask

   // -------------------------------------------------------------------------
   // main sequence
   // -------------------------------------------------------------------------
   initial begin
      cp = 1'b1;
      req = '0;
      void'($urandom(32'h368b));
      build_table();
      repeat (5) @(negedge ap);
      cp = 1'b0;
      @(negedge ap);
      assert (acc_word == '0)
         else stop_with_error($sformatf("Mismatch acc_word after reset: got %h expected 0",
                                        acc_word));
      assert (!busy && !overflow && !biq_error)
         else stop_with_error($sformatf(
            "Mismatch busy/overflow/biq_error after reset: got %h/%h/%h expected 0/0/0",
            busy, overflow, biq_error));
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      // let a few word times pass so a late stray pulse would be counted
      repeat (2 * `ARITH_SLOTS) next_cycle();
      assert (eop_count == n_rows)
         else stop_with_error($sformatf("Mismatch end_of_operation count: got %h expected %h",
                                        eop_count, n_rows));
      assert (!biq_error)
         else stop_with_error($sformatf("Mismatch biq_error at end of run: got %h expected 0",
                                        biq_error));
      $display("Finished with no errors");
      $finish;
   end

   // a row needs at most a gap wait plus one word time and the strobe cycles
   initial begin
      repeat ((n_rows + 2) * 30) @(posedge ap);
      stop_with_error("the watchdog ran out before all operations completed");
   end

endmodule

// ==== hw/arith_unit.sv ====
`timescale 1ns/1ps

module arith_unit (
   input  logic                  ap,
   input  logic                  cp,
   input  arith_pkg::arith_req_t req,
   output logic                  busy,
   output logic                  arith_restart,
   output logic                  end_of_operation,
   output arith_pkg::dec_word_t  acc_word,
   output logic                  overflow,
   output logic                  biq_error
);
   import arith_pkg::*;

   timing_t    timing;
   adder_ctl_t adder_ctl;
   biq_t       dist_digit;
   biq_t       acc_digit;
   biq_t       acc_upper;
   biq_t       adder_acc;
   biq_t       sum_digit;
   logic       load;
   logic       compl;
   logic       shift_sel;
   logic       write_en;
   logic       carry;

   digit_timing digit_timing_inst (
      .ap     (ap),
      .cp     (cp),
      .timing (timing)
   );

   distributor distributor_inst (
      .ap         (ap),
      .cp         (cp),
      .load       (load),
      .operand    (req.operand),
      .compl      (compl),
      .timing     (timing),
      .dist_digit (dist_digit)
   );

   // right shift reads the accumulator one place higher
   assign adder_acc = shift_sel ? acc_upper : acc_digit;

   biq_adder biq_adder_inst (
      .ap         (ap),
      .cp         (cp),
      .timing     (timing),
      .ctl        (adder_ctl),
      .acc_digit  (adder_acc),
      .dist_digit (dist_digit),
      .sum_digit  (sum_digit),
      .carry      (carry),
      .biq_error  (biq_error)
   );

   accumulator accumulator_inst (
      .ap        (ap),
      .cp        (cp),
      .timing    (timing),
      .write_en  (write_en),
      .sum_digit (sum_digit),
      .acc_digit (acc_digit),
      .acc_upper (acc_upper),
      .acc_word  (acc_word)
   );

   arith_ctl arith_ctl_inst (
      .ap               (ap),
      .cp               (cp),
      .timing           (timing),
      .req              (req),
      .carry            (carry),
      .busy             (busy),
      .load             (load),
      .compl            (compl),
      .adder_ctl        (adder_ctl),
      .shift_sel        (shift_sel),
      .write_en         (write_en),
      .arith_restart    (arith_restart),
      .end_of_operation (end_of_operation),
      .overflow         (overflow)
   );

endmodule

// ==== hw/arith_ctl.sv ====
`timescale 1ns/1ps

module arith_ctl (
   input  logic                  ap,
   input  logic                  cp,
   input  arith_pkg::timing_t    timing,
   input  arith_pkg::arith_req_t req,
   input  logic                  carry,
   output logic                  busy,
   output logic                  load,
   output logic                  compl,
   output arith_pkg::adder_ctl_t adder_ctl,
   output logic                  shift_sel,
   output logic                  write_en,
   output logic                  arith_restart,
   output logic                  end_of_operation,
   output logic                  overflow
);
   import arith_pkg::*;

   ctl_state_e state_q;
   ctl_state_e state_d;
   arith_op_e  op_q;
   logic       run;
   logic       first;
   logic       last;

   // -------------------------------------------------------------------------
   // operation sequencing
   // -------------------------------------------------------------------------

   // busy covers the wait for the gap and the running word time
   assign busy = (state_q == st_wait_dx) || (state_q == st_run);

   // a strobe while busy is dropped
   assign load = req.start && !busy;

   // the end state is the single cycle right after d10
   assign end_of_operation = (state_q == st_end);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle, st_end: begin
            state_d = load ? st_wait_dx : st_idle;
         end
         st_wait_dx: begin
            // the operation always starts on a whole word time
            if (timing.digit_hot.dx) begin
               state_d = st_run;
            end
         end
         st_run: begin
            if (timing.digit_hot.d10) begin
               state_d = st_end;
            end
         end
         default: begin
            state_d = st_idle;
         end
      endcase
   end

   always_ff @(posedge ap or posedge cp) begin
      if (cp) begin
         state_q <= st_idle;
         op_q <= op_reset_add;
         arith_restart <= 1'b0;
         overflow <= 1'b0;
      end else begin
         state_q <= state_d;
         if (load) begin
            op_q <= req.op;
         end
         // program control may fetch the next instruction from d5 on
         arith_restart <= run && timing.digit_hot.d4;
         // only add can run out of the top, every other operation clears it
         if (last) begin
            overflow <= (op_q == op_add) && carry;
         end
      end
   end

   // -------------------------------------------------------------------------
   // adder entry, carry and zero insert
   // -------------------------------------------------------------------------
   assign run = (state_q == st_run);
   assign first = run && timing.digit_hot.d1;
   assign last = run && timing.digit_hot.d10;

   always_comb begin
      // subtract adds the nines complement plus one in the units place
      adder_ctl.carry_insert = first && (op_q == op_subt);
      adder_ctl.carry_blank = first && (op_q != op_subt);
      // right shift empties the top digit, left shift the units digit
      adder_ctl.zero_insert = (last && (op_q == op_shift_right))
                            || (first && (op_q == op_shift_left));
      adder_ctl.use_acc = op_q inside {op_add, op_subt, op_shift_right};
      adder_ctl.use_dist = op_q inside {op_reset_add, op_add, op_subt};
   end

   assign compl = (op_q == op_subt);
   assign shift_sel = (op_q == op_shift_right);

   // every digit of the running word is rewritten with the adder output
   assign write_en = run;

   a_restart_not_eop : assert property (@(posedge ap) disable iff (cp)
      !(arith_restart && end_of_operation));

   a_carry_exclusive : assert property (@(posedge ap) disable iff (cp)
      !(adder_ctl.carry_insert && adder_ctl.carry_blank));

endmodule

// ==== hw/accumulator.sv ====
`timescale 1ns/1ps
`include "arith_params.svh"

module accumulator (
   input  logic                 ap,
   input  logic                 cp,
   input  arith_pkg::timing_t   timing,
   input  logic                 write_en,
   input  arith_pkg::biq_t      sum_digit,
   output arith_pkg::biq_t      acc_digit,
   output arith_pkg::biq_t      acc_upper,
   output arith_pkg::dec_word_t acc_word
);
   import arith_pkg::*;

   // stage 0 is the head, it holds the digit of the current slot
   biq_t stage_q [`ARITH_DIGITS];

   // one step per digit slot, so ten steps bring the word round once per
   // word time and the ring stands still in the gap
   always_ff @(posedge ap or posedge cp) begin
      if (cp) begin
         for (int i = 0; i < `ARITH_DIGITS; i++) begin
            stage_q[i] <= biq_zero;
         end
      end else if (!timing.digit_hot.dx) begin
         for (int i = 0; i < `ARITH_DIGITS - 1; i++) begin
            stage_q[i] <= stage_q[i + 1];
         end
         // the adder output enters at the tail, else the head recirculates
         stage_q[`ARITH_DIGITS - 1] <= write_en ? sum_digit : stage_q[0];
      end
   end

   assign acc_digit = stage_q[0];

   // next digit up for right shift, nothing lies above the top digit
   assign acc_upper = timing.digit_hot.d10 ? biq_zero : stage_q[1];

   // read-out follows the rotation, in slot dk the head holds digit k
   always_comb begin
      int offset;
      int pos;
      offset = timing.digit_hot.dx ? 0 : int'(timing.slot) - 1;
      for (int j = 0; j < `ARITH_DIGITS; j++) begin
         pos = (j + `ARITH_DIGITS - offset) % `ARITH_DIGITS;
         acc_word[j] = biq_to_bcd(stage_q[pos]);
      end
   end

   // a write in the gap would land while the ring stands still
   a_write_in_digit : assert property (@(posedge ap) disable iff (cp)
      write_en |-> !timing.digit_hot.dx);

endmodule

// ==== hw/biq_adder.sv ====
`timescale 1ns/1ps

module biq_adder (
   input  logic                  ap,
   input  logic                  cp,
   input  arith_pkg::timing_t    timing,
   input  arith_pkg::adder_ctl_t ctl,
   input  arith_pkg::biq_t       acc_digit,
   input  arith_pkg::biq_t       dist_digit,
   output arith_pkg::biq_t       sum_digit,
   output logic                  carry,
   output logic                  biq_error
);
   import arith_pkg::*;

   biq_t       acc_dly;
   biq_t       op_a;
   biq_t       op_b;
   logic       carry_q;
   logic       carry_in;
   logic       wrap;
   logic [4:0] raw_sum;
   bcd_t       digit;

   // -------------------------------------------------------------------------
   // operand entry
   // -------------------------------------------------------------------------

   // accumulator side is either the live digit, a zero for reset-add, or the
   // digit of the previous slot, which moves each digit up one place on a
   // left shift
   always_comb begin
      if (ctl.use_acc) begin
         op_a = acc_digit;
      end else if (ctl.use_dist) begin
         op_a = biq_zero;
      end else begin
         op_a = acc_dly;
      end
      op_b = ctl.use_dist ? dist_digit : biq_zero;
   end

   // -------------------------------------------------------------------------
   // one-digit sum
   // -------------------------------------------------------------------------
   always_comb begin
      // carry insert wins, carry blank drops the carry left over from before
      carry_in = carry_q;
      if (ctl.carry_insert) begin
         carry_in = 1'b1;
      end else if (ctl.carry_blank) begin
         carry_in = 1'b0;
      end
      raw_sum = 5'(biq_to_bcd(op_a)) + 5'(biq_to_bcd(op_b)) + 5'(carry_in);
      wrap = (raw_sum >= 5'd10);
      digit = wrap ? 4'(raw_sum - 5'd10) : raw_sum[3:0];
      // a zero-inserted digit produces no carry into the next place
      carry = wrap && !ctl.zero_insert;
      sum_digit = ctl.zero_insert ? biq_zero : bcd_to_biq(digit);
   end

   // carry ripples from one slot to the next and is emptied in the gap
   always_ff @(posedge ap or posedge cp) begin
      if (cp) begin
         carry_q <= 1'b0;
         biq_error <= 1'b0;
      end else begin
         carry_q <= timing.digit_hot.dx ? 1'b0 : carry;
         // sticky until reset so a single bad digit is not missed
         if (!timing.digit_hot.dx && !(biq_valid(op_a) && biq_valid(op_b))) begin
            biq_error <= 1'b1;
         end
      end
   end

   // digit of the previous slot
   always_ff @(posedge ap) begin
      acc_dly <= acc_digit;
   end

   // both feeding blocks must deliver good codes in every digit slot
   a_inputs_valid : assert property (@(posedge ap) disable iff (cp)
      !timing.digit_hot.dx |-> biq_valid(acc_digit) && biq_valid(dist_digit));

endmodule

// ==== hw/distributor.sv ====
`timescale 1ns/1ps

module distributor (
   input  logic                 ap,
   input  logic                 cp,
   input  logic                 load,
   input  arith_pkg::dec_word_t operand,
   input  logic                 compl,
   input  arith_pkg::timing_t   timing,
   output arith_pkg::biq_t      dist_digit
);
   import arith_pkg::*;

   dec_word_t word_q;
   bcd_t      digit;
   bcd_t      value;

   // the operand is taken in on the start strobe and held for the operation
   always_ff @(posedge ap or posedge cp) begin
      if (cp) begin
         word_q <= '0;
      end else if (load) begin
         word_q <= operand;
      end
   end

   // pick the digit that belongs to this slot, d1 reads the units digit
   always_comb begin
      digit = 4'd0;
      if (!timing.digit_hot.dx) begin
         digit = word_q[timing.slot - slot_t'(1)];
      end
      // subtraction feeds the nines complement, the unit adds the final one
      value = compl ? 4'd9 - digit : digit;
      // the gap slot carries a clean zero so the adder never sees a stale digit
      dist_digit = timing.digit_hot.dx ? biq_zero : bcd_to_biq(value);
   end

endmodule

// ==== hw/digit_timing.sv ====
`timescale 1ns/1ps
`include "arith_params.svh"

module digit_timing (
   input  logic               ap,
   input  logic               cp,
   output arith_pkg::timing_t timing
);
   import arith_pkg::*;

   slot_t                   slot_q;
   logic [`ARITH_SLOTS-1:0] hot;

   // the ring steps one slot per clock and wraps from d10 back to dx
   always_ff @(posedge ap or posedge cp) begin
      if (cp) begin
         slot_q <= '0;
      end else if (slot_q == slot_t'(`ARITH_SLOTS - 1)) begin
         slot_q <= '0;
      end else begin
         slot_q <= slot_q + slot_t'(1);
      end
   end

   // decode the slot number into one flag per slot
   always_comb begin
      hot = '0;
      hot[slot_q] = 1'b1;
      timing.slot = slot_q;
      timing.digit_hot = slot_hot_t'(hot);
   end

   // every block keys off these flags, two at once would double-step a digit
   a_slot_onehot : assert property (@(posedge ap) disable iff (cp)
      $onehot(timing.digit_hot));

endmodule

// ==== hw/arith_pkg.sv ====
`include "arith_params.svh"

package arith_pkg;

   // -------------------------------------------------------------------------
   // digit and word types
   // -------------------------------------------------------------------------

   // one digit in two-out-of-seven code
   typedef logic [`ARITH_BIQ_W-1:0] biq_t;

   // one digit in plain binary coded decimal
   typedef logic [3:0] bcd_t;

   // a whole word as read out of the accumulator, units digit at the low end
   typedef bcd_t [`ARITH_DIGITS-1:0] dec_word_t;

   // slot number, 0 is the dx gap and 1 to 10 are d1 to d10
   typedef logic [3:0] slot_t;

   // bi-0 and quinary 0 together make the digit zero
   localparam biq_t biq_zero = 7'b010_0001;

   typedef enum logic [2:0] {
      op_reset_add,
      op_add,
      op_subt,
      op_shift_right,
      op_shift_left
   } arith_op_e;

   typedef enum logic [1:0] {
      st_idle,
      st_wait_dx,
      st_run,
      st_end
   } ctl_state_e;

   // -------------------------------------------------------------------------
   // structs that travel between the blocks
   // -------------------------------------------------------------------------

   // one flag per slot, exactly one of them is high in every clock
   typedef struct packed {
      logic d10;
      logic d9;
      logic d8;
      logic d7;
      logic d6;
      logic d5;
      logic d4;
      logic d3;
      logic d2;
      logic d1;
      logic dx;
   } slot_hot_t;

   typedef struct packed {
      slot_t     slot;
      slot_hot_t digit_hot;
   } timing_t;

   // control lines from the arithmetic control into the one-digit adder
   typedef struct packed {
      logic carry_insert;
      logic carry_blank;
      logic zero_insert;
      logic use_acc;
      logic use_dist;
   } adder_ctl_t;

   // request from program control, start is a single-cycle strobe
   typedef struct packed {
      arith_op_e op;
      dec_word_t operand;
      logic      start;
   } arith_req_t;

   // -------------------------------------------------------------------------
   // code conversions
   // -------------------------------------------------------------------------

   // a digit of five or more lights bi-5 and the quinary line of the remainder
   function automatic biq_t bcd_to_biq(input bcd_t d);
      biq_t code;
      bcd_t q;
      code = '0;
      q = (d >= 4'd5) ? d - 4'd5 : d;
      code[6] = (d >= 4'd5);
      code[5] = (d < 4'd5);
      code[q[2:0]] = 1'b1;
      return code;
   endfunction

   // weight of the lit quinary line plus five when bi-5 is lit
   function automatic bcd_t biq_to_bcd(input biq_t code);
      bcd_t q;
      q = 4'd0;
      for (int i = 1; i < 5; i++) begin
         if (code[i]) begin
            q = 4'(i);
         end
      end
      return code[6] ? q + 4'd5 : q;
   endfunction

   // a good code has exactly one bi line and exactly one quinary line lit
   function automatic logic biq_valid(input biq_t code);
      return $onehot(code[6:5]) && $onehot(code[4:0]);
   endfunction

endpackage

// ==== include/arith_params.svh ====
`ifndef ARITH_PARAMS_SVH
`define ARITH_PARAMS_SVH

// decimal digits in one word, the units digit comes first in time
`define ARITH_DIGITS 10

// slots in one word time, the dx gap followed by one slot per digit
`define ARITH_SLOTS 11

// width of one bi-quinary digit
// bits 6 and 5 are the bi-5 and bi-0 lines, bits 4 to 0 the quinary lines
`define ARITH_BIQ_W 7

`endif
